//--- common/apu_pkg.sv
package apu_pkg;

// --------------------------------------------------
// register window.
localparam logic [15:0] base_addr = 16'h4000;
localparam logic [15:0] addr_status = 16'h4015;
localparam logic [15:0] addr_frame = 16'h4017;

// --------------------------------------------------
// channel tables.
localparam logic [7:0] length_lut [32] = '{
	8'd10, 8'd254, 8'd20, 8'd2, 8'd40, 8'd4, 8'd80, 8'd6,
	8'd160, 8'd8, 8'd60, 8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
	8'd12, 8'd16, 8'd24, 8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
	8'd192, 8'd24, 8'd72, 8'd26, 8'd16, 8'd28, 8'd32, 8'd30
};

// msb is sequencer step 0.
localparam logic [7:0] duty_lut [4] = '{
	8'b0100_0000, 8'b0110_0000, 8'b0111_1000, 8'b1001_1111
};

localparam logic [11:0] noise_period_lut [16] = '{
	12'd4, 12'd8, 12'd16, 12'd32, 12'd64, 12'd96, 12'd128, 12'd160,
	12'd202, 12'd254, 12'd380, 12'd508, 12'd762, 12'd1016, 12'd2034, 12'd4068
};

// --------------------------------------------------
// nonlinear mix, scaled so full scale is 255.
localparam logic [7:0] pulse_mix_lut [31] = '{
	8'd0, 8'd3, 8'd6, 8'd9, 8'd11, 8'd14, 8'd17, 8'd19,
	8'd22, 8'd24, 8'd27, 8'd29, 8'd31, 8'd34, 8'd36, 8'd38,
	8'd40, 8'd42, 8'd44, 8'd46, 8'd48, 8'd50, 8'd52, 8'd54,
	8'd56, 8'd58, 8'd59, 8'd61, 8'd63, 8'd64, 8'd66
};

localparam logic [7:0] noise_mix_lut [16] = '{
	8'd0, 8'd3, 8'd7, 8'd10, 8'd13, 8'd16, 8'd19, 8'd22,
	8'd25, 8'd28, 8'd31, 8'd34, 8'd36, 8'd39, 8'd42, 8'd44
};

// status byte: enables on write, flags on read.
typedef union packed {
	struct packed {
		logic [4:0] rsvd;
		logic noise;
		logic pulse1;
		logic pulse0;
	} wr;
	struct packed {
		logic rsvd7;
		logic frame_int;
		logic [2:0] rsvd;
		logic noise_act;
		logic pulse1_act;
		logic pulse0_act;
	} rd;
} status_word_u;

// one envelope clock, returns {divider, decay}.
function automatic logic [7:0] env_next(input logic start, input logic loop,
	input logic [3:0] vol, input logic [3:0] div, input logic [3:0] decay);
	logic [3:0] n_div;
	logic [3:0] n_decay;
	n_div = div;
	n_decay = decay;
	if (start) begin
		n_div = vol;
		n_decay = 4'd15;
	end else if (div == 4'd0) begin
		n_div = vol;
		if (decay != 4'd0)
			n_decay = decay - 4'd1;
		else if (loop)
			n_decay = 4'd15; // halt doubles as envelope loop.
	end else begin
		n_div = div - 4'd1;
	end
	return {n_div, n_decay};
endfunction

endpackage

//--- src/apu_length.sv
module apu_length (
	input logic clk,
	input logic n_reset,
	input logic load,
	input logic [4:0] index,
	input logic en,
	input logic halt,
	input logic half,
	output logic act
);

logic [7:0] cnt;

always_ff @(posedge clk, negedge n_reset)
	if (!n_reset)
		cnt <= 8'd0;
	else if (!en)
		cnt <= 8'd0; // disabled channel is silenced.
	else if (load)
		cnt <= apu_pkg::length_lut[index];
	else if (half && !halt && cnt != 8'd0)
		cnt <= cnt - 8'd1;

assign act = en && cnt != 8'd0;

no_wrap: assert property (@(posedge clk) disable iff (!n_reset)
	(cnt == 8'd0 && !load) |=> cnt == 8'd0);

endmodule

//--- src/apu_registers.sv
module apu_registers (
	input logic clk,
	input logic n_reset,
	input logic [15:0] sys_addr,
	input logic [7:0] sys_wdata,
	input logic sys_we,
	input logic sys_re,
	input logic frame_irq_set,
	input logic pulse0_act,
	input logic pulse1_act,
	input logic noise_act,
	output logic [7:0] sys_rdata,
	output logic sys_rdy,
	output logic wr_pulse0,
	output logic wr_pulse1,
	output logic wr_noise,
	output logic [1:0] wr_index,
	output logic [7:0] wr_data,
	output logic [2:0] ch_en,
	output logic frame_mode,
	output logic frame_inhibit,
	output logic frame_restart,
	output logic n_irq
);

logic in_win, wr, stat_read, frame_int;
apu_pkg::status_word_u st_wr, st_rd;

// --------------------------------------------------
// decode.
assign in_win = sys_addr >= apu_pkg::base_addr && sys_addr <= apu_pkg::addr_frame;
assign sys_rdy = in_win;
assign wr = sys_we && in_win;

assign wr_pulse0 = wr && sys_addr[4:2] == 3'd0;
assign wr_pulse1 = wr && sys_addr[4:2] == 3'd1;
assign wr_noise = wr && sys_addr[4:2] == 3'd3; // 4008..400b is triangle, unused.
assign wr_index = sys_addr[1:0];
assign wr_data = sys_wdata;

assign frame_restart = wr && sys_addr == apu_pkg::addr_frame;
assign stat_read = sys_re && sys_addr == apu_pkg::addr_status;

// --------------------------------------------------
// status and frame control.
assign st_wr = sys_wdata;

always_ff @(posedge clk, negedge n_reset)
	if (!n_reset) begin
		ch_en <= 3'b000;
		frame_mode <= 1'b0;
		frame_inhibit <= 1'b0;
	end else if (wr) begin
		if (sys_addr == apu_pkg::addr_status)
			ch_en <= {st_wr.wr.noise, st_wr.wr.pulse1, st_wr.wr.pulse0};
		if (sys_addr == apu_pkg::addr_frame)
			{frame_mode, frame_inhibit} <= sys_wdata[7:6];
	end

always_ff @(posedge clk, negedge n_reset)
	if (!n_reset)
		frame_int <= 1'b0;
	else if (frame_irq_set && !frame_inhibit)
		frame_int <= 1'b1;
	else if (frame_inhibit || stat_read)
		frame_int <= 1'b0; // reading status acknowledges.

assign n_irq = !frame_int;

always_comb begin
	st_rd = '0;
	st_rd.rd.frame_int = frame_int;
	st_rd.rd.noise_act = noise_act;
	st_rd.rd.pulse1_act = pulse1_act;
	st_rd.rd.pulse0_act = pulse0_act;
end

assign sys_rdata = stat_read ? st_rd : 8'h00;

one_strobe: assert property (@(posedge clk) disable iff (!n_reset)
	$onehot0({wr_pulse0, wr_pulse1, wr_noise}));

endmodule

//--- src/apu_frame_seq.sv
module apu_frame_seq #(
	parameter int FRAME_PERIOD = 3728
) (
	input logic clk,
	input logic n_reset,
	input logic frame_mode,
	input logic frame_restart,
	output logic apu_tick,
	output logic quarter,
	output logic half,
	output logic frame_irq_set
);

localparam int CW = $clog2(FRAME_PERIOD + 1);

logic [CW-1:0] cnt;
logic [2:0] step;
logic step_end, last_step, fire;

// apu clock runs at half of clk.
always_ff @(posedge clk, negedge n_reset)
	if (!n_reset)
		apu_tick <= 1'b0;
	else
		apu_tick <= !apu_tick;

assign step_end = apu_tick && cnt == CW'(FRAME_PERIOD - 1);
assign last_step = frame_mode ? step == 3'd4 : step == 3'd3;
assign fire = step_end && !frame_restart;

// --------------------------------------------------
// step counter.
always_ff @(posedge clk, negedge n_reset)
	if (!n_reset) begin
		cnt <= '0;
		step <= 3'd0;
	end else if (frame_restart) begin
		cnt <= '0;
		step <= 3'd0;
	end else if (apu_tick) begin
		if (step_end) begin
			cnt <= '0;
			step <= last_step ? 3'd0 : step + 3'd1;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

// --------------------------------------------------
// frame pulses, steps counted from 0 here.
always_ff @(posedge clk, negedge n_reset)
	if (!n_reset) begin
		quarter <= 1'b0;
		half <= 1'b0;
		frame_irq_set <= 1'b0;
	end else begin
		quarter <= fire && !(frame_mode && step == 3'd3); // 5-step skips step 4.
		half <= fire && (step == 3'd1 || last_step);
		frame_irq_set <= fire && !frame_mode && step == 3'd3;
	end

step_range: assert property (@(posedge clk) disable iff (!n_reset)
	step <= (frame_mode ? 3'd4 : 3'd3));

endmodule

//--- pulse/apu_pulse.sv
module apu_pulse (
	input logic clk,
	input logic n_reset,
	input logic wr,
	input logic [1:0] wr_index,
	input logic [7:0] wr_data,
	input logic en,
	input logic apu_tick,
	input logic quarter,
	input logic half,
	output logic act,
	output logic [3:0] sample
);

logic [1:0] duty;
logic halt, const_vol;
logic [3:0] volume;
logic [10:0] reload, timer;
logic [2:0] seq;
logic env_start;
logic [3:0] env_div, env_decay;
logic duty_bit, restart;

assign restart = wr && wr_index == 2'd3;

// register 1 is the sweep unit, not present.
always_ff @(posedge clk, negedge n_reset)
	if (!n_reset) begin
		{duty, halt, const_vol, volume} <= 8'h00;
		reload <= 11'd0;
	end else if (wr) begin
		case (wr_index)
		2'd0: {duty, halt, const_vol, volume} <= wr_data;
		2'd2: reload[7:0] <= wr_data;
		2'd3: reload[10:8] <= wr_data[2:0];
		default: ;
		endcase
	end

// --------------------------------------------------
// timer and duty sequencer.
always_ff @(posedge clk, negedge n_reset)
	if (!n_reset) begin
		timer <= 11'd0;
		seq <= 3'd0;
	end else if (restart) begin
		seq <= 3'd0;
	end else if (apu_tick) begin
		if (timer == 11'd0) begin
			timer <= reload;
			seq <= seq + 3'd1;
		end else begin
			timer <= timer - 11'd1;
		end
	end

// envelope.
always_ff @(posedge clk, negedge n_reset)
	if (!n_reset) begin
		env_start <= 1'b0;
		{env_div, env_decay} <= 8'h00;
	end else if (restart) begin
		env_start <= 1'b1;
	end else if (quarter) begin
		{env_div, env_decay} <= apu_pkg::env_next(env_start, halt, volume,
			env_div, env_decay);
		env_start <= 1'b0;
	end

apu_length len0 (.clk(clk), .n_reset(n_reset), .load(restart), .index(wr_data[7:3]),
	.en(en), .halt(halt), .half(half), .act(act));

assign duty_bit = apu_pkg::duty_lut[duty][3'd7 - seq];
assign sample = (act && duty_bit) ? (const_vol ? volume : env_decay) : 4'd0;

endmodule

//--- src/apu_noise.sv
module apu_noise (
	input logic clk,
	input logic n_reset,
	input logic wr,
	input logic [1:0] wr_index,
	input logic [7:0] wr_data,
	input logic en,
	input logic apu_tick,
	input logic quarter,
	input logic half,
	output logic act,
	output logic [3:0] sample
);

logic halt, const_vol, mode;
logic [3:0] volume, period;
logic [11:0] timer;
logic [14:0] lfsr;
logic env_start, restart, fb;
logic [3:0] env_div, env_decay;

assign restart = wr && wr_index == 2'd3;

always_ff @(posedge clk, negedge n_reset)
	if (!n_reset) begin
		{halt, const_vol, volume} <= 6'h00;
		{mode, period} <= 5'h00;
	end else if (wr) begin
		if (wr_index == 2'd0)
			{halt, const_vol, volume} <= wr_data[5:0];
		if (wr_index == 2'd2)
			{mode, period} <= {wr_data[7], wr_data[3:0]};
	end

// --------------------------------------------------
assign fb = lfsr[0] ^ (mode ? lfsr[6] : lfsr[1]); // short mode taps bit 6.

always_ff @(posedge clk, negedge n_reset)
	if (!n_reset) begin
		timer <= 12'd0;
		lfsr <= 15'd1;
	end else if (apu_tick) begin
		if (timer == 12'd0) begin
			timer <= apu_pkg::noise_period_lut[period];
			lfsr <= {fb, lfsr[14:1]};
		end else begin
			timer <= timer - 12'd1;
		end
	end

always_ff @(posedge clk, negedge n_reset)
	if (!n_reset) begin
		env_start <= 1'b0;
		{env_div, env_decay} <= 8'h00;
	end else if (restart) begin
		env_start <= 1'b1;
	end else if (quarter) begin
		{env_div, env_decay} <= apu_pkg::env_next(env_start, halt, volume,
			env_div, env_decay);
		env_start <= 1'b0;
	end

apu_length len0 (.clk(clk), .n_reset(n_reset), .load(restart), .index(wr_data[7:3]),
	.en(en), .halt(halt), .half(half), .act(act));

assign sample = (act && !lfsr[0]) ? (const_vol ? volume : env_decay) : 4'd0;

endmodule

//--- src/apu_mixer.sv
module apu_mixer (
	input logic clk,
	input logic n_reset,
	input logic [3:0] pulse0,
	input logic [3:0] pulse1,
	input logic [3:0] noise,
	output logic [7:0] out
);

logic [4:0] pulse_sum;
logic [8:0] mix;

assign pulse_sum = 5'(pulse0) + 5'(pulse1);
assign mix = 9'(apu_pkg::pulse_mix_lut[pulse_sum]) + 9'(apu_pkg::noise_mix_lut[noise]);

always_ff @(posedge clk, negedge n_reset)
	if (!n_reset)
		out <= 8'h00;
	else
		out <= mix[8] ? 8'hff : mix[7:0]; // saturate.

endmodule

//--- src/apu.sv
module apu #(
	parameter int FRAME_PERIOD = 3728
) (
	input logic clk,
	input logic n_reset,
	input logic [15:0] sys_addr,
	input logic [7:0] sys_wdata,
	input logic sys_we,
	input logic sys_re,
	output logic [7:0] sys_rdata,
	output logic sys_rdy,
	output logic n_irq,
	output logic [7:0] out
);

logic wr_pulse0, wr_pulse1, wr_noise;
logic [1:0] wr_index;
logic [7:0] wr_data;
logic [2:0] ch_en;
logic frame_mode, frame_inhibit, frame_restart, frame_irq_set;
logic apu_tick, quarter, half;
logic pulse0_act, pulse1_act, noise_act;
logic [3:0] pulse0, pulse1, noise;

apu_registers regs0 (.clk(clk), .n_reset(n_reset),
	.sys_addr(sys_addr), .sys_wdata(sys_wdata), .sys_we(sys_we), .sys_re(sys_re),
	.frame_irq_set(frame_irq_set), .pulse0_act(pulse0_act), .pulse1_act(pulse1_act),
	.noise_act(noise_act), .sys_rdata(sys_rdata), .sys_rdy(sys_rdy),
	.wr_pulse0(wr_pulse0), .wr_pulse1(wr_pulse1), .wr_noise(wr_noise),
	.wr_index(wr_index), .wr_data(wr_data), .ch_en(ch_en), .frame_mode(frame_mode),
	.frame_inhibit(frame_inhibit), .frame_restart(frame_restart), .n_irq(n_irq));

apu_frame_seq #(.FRAME_PERIOD(FRAME_PERIOD)) seq0 (.clk(clk), .n_reset(n_reset),
	.frame_mode(frame_mode), .frame_restart(frame_restart), .apu_tick(apu_tick),
	.quarter(quarter), .half(half), .frame_irq_set(frame_irq_set));

apu_pulse p0 (.clk(clk), .n_reset(n_reset), .wr(wr_pulse0), .wr_index(wr_index),
	.wr_data(wr_data), .en(ch_en[0]), .apu_tick(apu_tick), .quarter(quarter),
	.half(half), .act(pulse0_act), .sample(pulse0));

apu_pulse p1 (.clk(clk), .n_reset(n_reset), .wr(wr_pulse1), .wr_index(wr_index),
	.wr_data(wr_data), .en(ch_en[1]), .apu_tick(apu_tick), .quarter(quarter),
	.half(half), .act(pulse1_act), .sample(pulse1));

apu_noise n0 (.clk(clk), .n_reset(n_reset), .wr(wr_noise), .wr_index(wr_index),
	.wr_data(wr_data), .en(ch_en[2]), .apu_tick(apu_tick), .quarter(quarter),
	.half(half), .act(noise_act), .sample(noise));

apu_mixer mix0 (.clk(clk), .n_reset(n_reset), .pulse0(pulse0), .pulse1(pulse1),
	.noise(noise), .out(out));

endmodule

//--- sim/apu_checker.sv
module apu_checker (
	input logic clk,
	input logic [7:0] sys_rdata,
	input logic sys_rdy,
	input logic n_irq,
	input logic [7:0] out,
	input logic start,
	input logic close,
	input logic [2:0] kind,
	input logic [7:0] expected,
	input int test_num,
	output int pass_count,
	output int fail_count
);
timeunit 1ns;
timeprecision 100ps;

localparam logic [2:0] kind_rdata = 3'd1;
localparam logic [2:0] kind_rdy = 3'd2;
localparam logic [2:0] kind_irq = 3'd3;
localparam logic [2:0] kind_out = 3'd4;
localparam logic [2:0] kind_pulse = 3'd5;
localparam logic [2:0] kind_noise = 3'd6;

logic watching, seen_zero, seen_level, stray;
logic [7:0] level, stray_val;
logic [2:0] win_kind;
int win_test;

task automatic score(input int num, input logic ok, input string what, input int got,
	input int want);
	if (ok) begin
		pass_count++;
		$display("test %0d passed, %s", num, what);
	end else begin
		fail_count++;
		$display("CHECK FAILED at %0t: test %0d, %s is %0d, expected %0d", $time, num,
			what, got, want);
	end
endtask

initial begin
	pass_count = 0;
	fail_count = 0;
	watching = 1'b0;
end

// values seen here are the ones from just before the edge.
always @(posedge clk) begin
	if (watching) begin
		if (out == 8'd0)
			seen_zero = 1'b1;
		else if (out == level)
			seen_level = 1'b1;
		else if (!stray) begin
			stray = 1'b1;
			stray_val = out; // first bad value only.
		end
	end
	if (close && watching) begin
		watching = 1'b0;
		if (stray)
			score(win_test, 1'b0, "out", stray_val, level);
		else if (win_kind == kind_pulse)
			score(win_test, seen_zero && seen_level, "number of out levels seen",
				int'(seen_zero) + int'(seen_level), 2);
		else
			score(win_test, seen_level, "noise level seen", int'(seen_level), 1);
	end
	if (start) begin
		case (kind)
		kind_rdata: score(test_num, sys_rdata == expected, "status read", sys_rdata, expected);
		kind_rdy: score(test_num, sys_rdy == expected[0], "sys_rdy", sys_rdy, expected[0]);
		kind_irq: score(test_num, n_irq == expected[0], "n_irq", n_irq, expected[0]);
		kind_out: score(test_num, out == expected, "out", out, expected);
		kind_pulse, kind_noise: begin
			watching = 1'b1;
			win_kind = kind;
			win_test = test_num;
			seen_zero = 1'b0;
			seen_level = 1'b0;
			stray = 1'b0;
			level = (kind == kind_pulse) ? apu_pkg::pulse_mix_lut[expected[3:0]]
				: apu_pkg::noise_mix_lut[expected[3:0]];
		end
		default: ;
		endcase
	end
end

endmodule

//--- sim/apu_tb.sv
module apu_tb;
timeunit 1ns;
timeprecision 100ps;

localparam logic [1:0] op_none = 2'd0;
localparam logic [1:0] op_wr = 2'd1;
localparam logic [1:0] op_rd = 2'd2;
localparam logic [2:0] kind_none = 3'd0;
localparam logic [2:0] kind_rdata = 3'd1;
localparam logic [2:0] kind_rdy = 3'd2;
localparam logic [2:0] kind_irq = 3'd3;
localparam logic [2:0] kind_out = 3'd4;
localparam logic [2:0] kind_pulse = 3'd5;
localparam logic [2:0] kind_noise = 3'd6;
localparam int frame_period = 8;
localparam int step_clks = 2 * frame_period; // apu tick is every other clk.
localparam int half_clks = 2 * step_clks; // 4-step mode, half on steps 2 and 4.
localparam int seq_clks = 4 * step_clks;
localparam int max_entries = 64;

logic clk, n_reset;
logic [15:0] sys_addr;
logic [7:0] sys_wdata, sys_rdata, out;
logic sys_we, sys_re, sys_rdy, n_irq;
logic start, close;
logic [2:0] kind;
logic [7:0] expected;
int test_num, pass_count, fail_count;

// --------------------------------------------------
// stimulus table.
logic [15:0] t_addr [max_entries];
logic [7:0] t_data [max_entries];
logic [1:0] t_op [max_entries];
int t_wait [max_entries];
logic [7:0] t_exp [max_entries];
logic [2:0] t_kind [max_entries];
int n_entries, n_checks, limit, seed;

apu #(.FRAME_PERIOD(frame_period)) UUT (.clk(clk), .n_reset(n_reset), .sys_addr(sys_addr),
	.sys_wdata(sys_wdata), .sys_we(sys_we), .sys_re(sys_re), .sys_rdata(sys_rdata),
	.sys_rdy(sys_rdy), .n_irq(n_irq), .out(out));

apu_checker chk (.clk(clk), .sys_rdata(sys_rdata), .sys_rdy(sys_rdy), .n_irq(n_irq),
	.out(out), .start(start), .close(close), .kind(kind), .expected(expected),
	.test_num(test_num), .pass_count(pass_count), .fail_count(fail_count));

always #20 clk = !clk;

task automatic add_entry(input logic [15:0] addr, input logic [7:0] data,
	input logic [1:0] op, input int wait_cyc, input logic [7:0] exp, input logic [2:0] k);
	t_addr[n_entries] = addr;
	t_data[n_entries] = data;
	t_op[n_entries] = op;
	t_wait[n_entries] = wait_cyc;
	t_exp[n_entries] = exp;
	t_kind[n_entries] = k;
	n_entries++;
	if (k != kind_none)
		n_checks++;
endtask

task automatic write_reg(input logic [15:0] addr, input logic [7:0] data, input int wait_cyc);
	add_entry(addr, data, op_wr, wait_cyc, 8'h00, kind_none);
endtask

task automatic build_table();
	logic [3:0] pulse_vol, noise_vol;
	logic [4:0] len_idx;
	int len;
	pulse_vol = 4'd1 + 4'($unsigned($random(seed)) % 15); // never 0, so the level shows.
	noise_vol = 4'd1 + 4'($unsigned($random(seed)) % 15);
	len_idx = 5'($random(seed));
	len = apu_pkg::length_lut[len_idx];
	// after reset.
	add_entry(16'h0000, 8'h00, op_none, 0, 8'h01, kind_irq);
	add_entry(16'h0000, 8'h00, op_none, 0, 8'h00, kind_out);
	add_entry(apu_pkg::addr_status, 8'h00, op_rd, 0, 8'h00, kind_rdata);
	add_entry(16'h3fff, 8'h00, op_none, 0, 8'h00, kind_rdy);
	add_entry(apu_pkg::base_addr, 8'h00, op_none, 0, 8'h01, kind_rdy);
	add_entry(apu_pkg::addr_frame, 8'h00, op_none, 0, 8'h01, kind_rdy);
	add_entry(16'h4018, 8'h00, op_none, 0, 8'h00, kind_rdy);
	// frame interrupt, then 5-step mode and inhibit.
	write_reg(apu_pkg::addr_frame, 8'h00, seq_clks + 8);
	add_entry(16'h0000, 8'h00, op_none, 0, 8'h00, kind_irq);
	add_entry(apu_pkg::addr_status, 8'h00, op_rd, 0, 8'h40, kind_rdata);
	add_entry(16'h0000, 8'h00, op_none, 0, 8'h01, kind_irq);
	write_reg(apu_pkg::addr_frame, 8'h80, 3 * seq_clks);
	add_entry(16'h0000, 8'h00, op_none, 0, 8'h01, kind_irq);
	write_reg(apu_pkg::addr_frame, 8'h40, 3 * seq_clks);
	add_entry(16'h0000, 8'h00, op_none, 0, 8'h01, kind_irq);
	add_entry(apu_pkg::addr_status, 8'h00, op_rd, 0, 8'h00, kind_rdata);
	// --------------------------------------------------
	// act bits follow enables and length loads.
	write_reg(apu_pkg::addr_status, 8'h07, 0);
	write_reg(16'h4003, {len_idx, 3'b000}, 0);
	write_reg(16'h4007, {len_idx, 3'b000}, 0);
	write_reg(16'h400f, {len_idx, 3'b000}, 0);
	add_entry(apu_pkg::addr_status, 8'h00, op_rd, 0, 8'h07, kind_rdata);
	write_reg(apu_pkg::addr_status, 8'h05, 0);
	add_entry(apu_pkg::addr_status, 8'h00, op_rd, 0, 8'h05, kind_rdata);
	write_reg(apu_pkg::addr_status, 8'h00, 0);
	add_entry(apu_pkg::addr_status, 8'h00, op_rd, 0, 8'h00, kind_rdata);
	// length count runs out, sequencer restarted just before the load.
	write_reg(apu_pkg::addr_status, 8'h01, 0);
	write_reg(apu_pkg::addr_frame, 8'h40, 0);
	write_reg(16'h4003, {len_idx, 3'b000}, (len - 1) * half_clks + step_clks);
	add_entry(apu_pkg::addr_status, 8'h00, op_rd, 2 * half_clks, 8'h01, kind_rdata);
	add_entry(apu_pkg::addr_status, 8'h00, op_rd, 0, 8'h00, kind_rdata);
	// --------------------------------------------------
	// pulse1 alone, 50 percent duty, halted length.
	write_reg(apu_pkg::addr_status, 8'h02, 0);
	write_reg(16'h4004, 8'hb0 | 8'(pulse_vol), 0);
	write_reg(16'h4006, 8'h04, 0);
	write_reg(16'h4007, 8'h08, 0);
	add_entry(16'h0000, 8'h00, op_none, 200, 8'(pulse_vol), kind_pulse);
	// noise alone.
	write_reg(apu_pkg::addr_status, 8'h04, 0);
	write_reg(16'h400c, 8'h30 | 8'(noise_vol), 0);
	write_reg(16'h400e, 8'h00, 0);
	write_reg(16'h400f, 8'h08, 0);
	add_entry(16'h0000, 8'h00, op_none, 200, 8'(noise_vol), kind_noise);
	write_reg(apu_pkg::addr_status, 8'h00, 0);
endtask

// called on a falling edge, returns on a falling edge.
task automatic apply_entry(input int i);
	sys_addr = t_addr[i];
	sys_wdata = t_data[i];
	sys_we = t_op[i] == op_wr;
	sys_re = t_op[i] == op_rd;
	kind = t_kind[i];
	expected = t_exp[i];
	test_num = i;
	start = 1'b1;
	@(negedge clk);
	start = 1'b0;
	sys_we = 1'b0;
	sys_re = 1'b0;
	sys_addr = 16'h0000;
	repeat (t_wait[i]) @(negedge clk);
	if (t_kind[i] == kind_pulse || t_kind[i] == kind_noise) begin
		close = 1'b1;
		@(negedge clk);
		close = 1'b0;
	end
endtask

// watchdog.
initial begin
	wait (limit > 0);
	repeat (limit) @(posedge clk);
	$display("timeout, the test table did not finish within %0d clock cycles", limit);
	$display("tests failed");
	$finish;
end

initial begin
	clk = 1'b0;
	n_reset = 1'b0;
	sys_addr = 16'h0000;
	sys_wdata = 8'h00;
	sys_we = 1'b0;
	sys_re = 1'b0;
	start = 1'b0;
	close = 1'b0;
	kind = kind_none;
	expected = 8'h00;
	test_num = 0;
	n_entries = 0;
	n_checks = 0;
	seed = 32'h5b7f_3fef;
	build_table();
	limit = 5 + 100;
	for (int i = 0; i < n_entries; i++)
		limit += t_wait[i] + 2;
	repeat (5) @(negedge clk);
	n_reset = 1'b1;
	@(negedge clk);
	for (int i = 0; i < n_entries; i++)
		apply_entry(i);
	@(negedge clk);
	$display("checks run %0d, passed %0d, failed %0d", pass_count + fail_count,
		pass_count, fail_count);
	if (pass_count + fail_count != n_checks)
		$display("only %0d of %0d checks were evaluated", pass_count + fail_count, n_checks);
	if (fail_count == 0 && pass_count == n_checks)
		$display("all tests passed");
	else
		$display("tests failed");
	$finish;
end

endmodule

//--- list.f
common/apu_pkg.sv
src/apu_length.sv
src/apu_registers.sv
src/apu_frame_seq.sv
pulse/apu_pulse.sv
src/apu_noise.sv
src/apu_mixer.sv
src/apu.sv
sim/apu_checker.sv
sim/apu_tb.sv
